// ==== src/watchPkg.sv ====
package watchPkg;

  localparam int addrW = 32;
  localparam int dataW = 32;
  localparam int byteEnW = 4;
  localparam int respW = 2;

  typedef struct packed {
    logic valid;
    logic [addrW-1:0] addr;
  } iReqT;

  typedef struct packed {
    logic read;
    logic write;
    logic [byteEnW-1:0] byteEn;
    logic [addrW-1:0] addr;
  } dReqT;

  typedef struct packed {
    logic [addrW-1:0] addr;
  } iSampleT;

  typedef struct packed {
    logic write;
    logic [byteEnW-1:0] byteEn;
    logic [addrW-1:0] addr;
    logic [dataW-1:0] data;
  } dSampleT;

  typedef struct packed {
    logic awvalid;
    logic [addrW-1:0] awaddr;
    logic wvalid;
    logic [dataW-1:0] wdata;
    logic [byteEnW-1:0] wstrb;
    logic bready;
    logic arvalid;
    logic [addrW-1:0] araddr;
    logic rready;
  } axiLiteReqT;

  typedef struct packed {
    logic awready;
    logic wready;
    logic bvalid;
    logic [respW-1:0] bresp;
    logic arready;
    logic rvalid;
    logic [dataW-1:0] rdata;
    logic [respW-1:0] rresp;
  } axiLiteRspT;

  // register map, one word each
  localparam logic [addrW-1:0] regCtrl = 32'h00;
  localparam logic [addrW-1:0] regIWatch = 32'h04;
  localparam logic [addrW-1:0] regIMask = 32'h08;
  localparam logic [addrW-1:0] regDWatch = 32'h0C;
  localparam logic [addrW-1:0] regDMask = 32'h10;
  localparam logic [addrW-1:0] regStatus = 32'h14;
  localparam logic [addrW-1:0] regIHitAddr = 32'h18;
  localparam logic [addrW-1:0] regDHitAddr = 32'h1C;

  localparam logic [respW-1:0] respOkay = 2'b00;

endpackage

// ==== src/missTracker.sv ====
`timescale 1ns/100ps

module missTracker
(
  input  logic CLK,
  input  logic arstN,
  input  watchPkg::iReqT iReq,
  input  logic iMiss,
  input  logic iFill,
  input  logic dMiss,
  input  logic dFill,
  output logic iBusy,
  output logic dBusy,
  output logic iFillSeen,
  output logic dFillSeen,
  output logic [watchPkg::addrW-1:0] fetchAddr
);

  logic iPendR;
  logic dPendR;

  // busy covers the miss cycle itself and runs through the fill cycle
  assign iBusy = iPendR | iMiss;
  assign dBusy = dPendR | dMiss;

  always_ff @(posedge CLK or negedge arstN)
  begin
    if (!arstN)
    begin
      iPendR <= 1'b0;
      dPendR <= 1'b0;
      iFillSeen <= 1'b0;
      dFillSeen <= 1'b0;
    end
    else
    begin
      iPendR <= iMiss | (iPendR & ~iFill);
      dPendR <= dMiss | (dPendR & ~dFill);
      // marks the cycle after the refill
      iFillSeen <= iFill & iPendR;
      dFillSeen <= dFill & dPendR;
    end
  end

  // new fetches are ignored while a miss is outstanding
  always_ff @(posedge CLK)
  begin
    if (iReq.valid && !iBusy)
    begin
      fetchAddr <= iReq.addr;
    end
  end

endmodule

// ==== src/accessSampler.sv ====
`timescale 1ns/100ps

module accessSampler
(
  input  logic CLK,
  input  logic arstN,
  input  watchPkg::iReqT iReq,
  input  watchPkg::dReqT dReq,
  input  logic iMiss,
  input  logic iFill,
  input  logic dMiss,
  input  logic dFill,
  input  logic xcpn,
  input  logic [watchPkg::dataW-1:0] storeData,
  input  logic [watchPkg::dataW-1:0] loadData,
  input  logic [watchPkg::dataW-1:0] fillData,
  output logic iSample,
  output watchPkg::iSampleT iSampleData,
  output logic dSample,
  output watchPkg::dSampleT dSampleData
);

  logic iBusy;
  logic dBusy;
  logic iFillSeen;
  logic dFillSeen;
  logic [watchPkg::addrW-1:0] fetchAddr;

  // instruction S stage
  logic sRead;
  logic iPend;

  // data M and W stages
  logic mRead;
  logic mWrite;
  logic [watchPkg::byteEnW-1:0] mByteEn;
  logic [watchPkg::addrW-1:0] mAddr;
  logic wRead;
  logic wWrite;
  logic [watchPkg::byteEnW-1:0] wByteEn;
  logic [watchPkg::addrW-1:0] wAddr;
  logic [watchPkg::dataW-1:0] wData;
  logic dPend;

  missTracker i_missTracker
  (
    .CLK       (CLK),
    .arstN     (arstN),
    .iReq      (iReq),
    .iMiss     (iMiss),
    .iFill     (iFill),
    .dMiss     (dMiss),
    .dFill     (dFill),
    .iBusy     (iBusy),
    .dBusy     (dBusy),
    .iFillSeen (iFillSeen),
    .dFillSeen (dFillSeen),
    .fetchAddr (fetchAddr)
  );

  always_ff @(posedge CLK or negedge arstN)
  begin
    if (!arstN)
    begin
      sRead <= 1'b0;
      iPend <= 1'b0;
      mRead <= 1'b0;
      mWrite <= 1'b0;
      wRead <= 1'b0;
      wWrite <= 1'b0;
      dPend <= 1'b0;
    end
    else
    begin
      sRead <= iReq.valid & ~iBusy;
      iPend <= (sRead & iMiss) | (iPend & ~iFillSeen);
      dPend <= (wRead & dMiss) | (dPend & ~dFillSeen);
      if (dBusy)
      begin
        // frozen, but an exception still kills the access in M
        mRead <= mRead & ~xcpn;
        mWrite <= mWrite & ~xcpn;
      end
      else
      begin
        mRead <= dReq.read;
        mWrite <= dReq.write;
        wRead <= mRead & ~xcpn;
        wWrite <= mWrite & ~xcpn;
      end
    end
  end

  always_ff @(posedge CLK)
  begin
    if (!dBusy)
    begin
      mByteEn <= dReq.byteEn;
      mAddr <= dReq.addr;
      wByteEn <= mByteEn;
      wAddr <= mAddr;
    end
    if (dFill)
    begin
      wData <= fillData;
    end
  end

  assign iSample = (sRead & ~iMiss) | (iPend & iFillSeen);
  assign iSampleData = '{addr: fetchAddr};

  assign dSample = wWrite | (wRead & ~dMiss & ~dPend) | (dPend & dFillSeen);

  always_comb
  begin
    dSampleData.write = wWrite;
    dSampleData.byteEn = wByteEn;
    dSampleData.addr = wAddr;
    if (dPend)
      dSampleData.data = wData;
    else if (wWrite)
      dSampleData.data = storeData;
    else
      dSampleData.data = loadData;
  end

endmodule

// ==== src/watchMatcher.sv ====
`timescale 1ns/100ps

module watchMatcher
#(
  parameter type sampleT = watchPkg::iSampleT
)
(
  input  logic CLK,
  input  logic arstN,
  input  logic enable,
  input  logic [watchPkg::addrW-1:0] watchAddr,
  input  logic [watchPkg::addrW-1:0] watchMask,
  input  logic sampleValid,
  input  sampleT sample,
  output logic hit,
  output logic [watchPkg::addrW-1:0] hitAddr
);

  logic [watchPkg::addrW-1:0] diff;
  logic match;

  // only bits set in the mask take part in the compare
  assign diff = (sample.addr ^ watchAddr) & watchMask;
  assign match = enable & sampleValid & (diff == '0);

  always_ff @(posedge CLK or negedge arstN)
  begin
    if (!arstN)
    begin
      hit <= 1'b0;
    end
    else
    begin
      hit <= match;
    end
  end

  always_ff @(posedge CLK)
  begin
    if (match)
    begin
      hitAddr <= sample.addr;
    end
  end

endmodule

// ==== src/watchRegs.sv ====
`timescale 1ns/100ps

module watchRegs
(
  input  logic CLK,
  input  logic arstN,
  input  watchPkg::axiLiteReqT axiReq,
  output watchPkg::axiLiteRspT axiRsp,
  input  logic iHit,
  input  logic dHit,
  input  logic [watchPkg::addrW-1:0] iHitAddr,
  input  logic [watchPkg::addrW-1:0] dHitAddr,
  output logic iEnable,
  output logic dEnable,
  output logic [watchPkg::addrW-1:0] iWatch,
  output logic [watchPkg::addrW-1:0] iMask,
  output logic [watchPkg::addrW-1:0] dWatch,
  output logic [watchPkg::addrW-1:0] dMask,
  output logic irq
);

  logic [1:0] ctrl;
  logic [1:0] status;
  logic [watchPkg::addrW-1:0] iHitAddrR;
  logic [watchPkg::addrW-1:0] dHitAddrR;
  logic bValid;
  logic rValid;
  logic [watchPkg::dataW-1:0] rData;
  logic wrFire;
  logic rdFire;
  logic [1:0] statusClr;
  logic [watchPkg::dataW-1:0] rdMux;

  function automatic logic [watchPkg::dataW-1:0] mergeStrb
  (
    input logic [watchPkg::dataW-1:0] old,
    input logic [watchPkg::dataW-1:0] data,
    input logic [watchPkg::byteEnW-1:0] strb
  );
    logic [watchPkg::dataW-1:0] res;
    res = old;
    for (int b = 0; b < watchPkg::byteEnW; b++)
    begin
      if (strb[b])
        res[8*b +: 8] = data[8*b +: 8];
    end
    return res;
  endfunction

  // address and data are taken together, one write in flight
  assign wrFire = axiReq.awvalid & axiReq.wvalid & ~bValid;
  assign rdFire = axiReq.arvalid & ~rValid;

  assign statusClr = (wrFire && axiReq.awaddr == watchPkg::regStatus) ?
                     axiReq.wdata[1:0] & {2{axiReq.wstrb[0]}} : 2'b00;

  always_comb
  begin
    case (axiReq.araddr)
      watchPkg::regCtrl:     rdMux = {{(watchPkg::dataW-2){1'b0}}, ctrl};
      watchPkg::regIWatch:   rdMux = iWatch;
      watchPkg::regIMask:    rdMux = iMask;
      watchPkg::regDWatch:   rdMux = dWatch;
      watchPkg::regDMask:    rdMux = dMask;
      watchPkg::regStatus:   rdMux = {{(watchPkg::dataW-2){1'b0}}, status};
      watchPkg::regIHitAddr: rdMux = iHitAddrR;
      watchPkg::regDHitAddr: rdMux = dHitAddrR;
      default:               rdMux = '0;
    endcase
  end

  always_ff @(posedge CLK or negedge arstN)
  begin
    if (!arstN)
    begin
      ctrl <= '0;
      iWatch <= '0;
      iMask <= '0;
      dWatch <= '0;
      dMask <= '0;
      status <= '0;
      iHitAddrR <= '0;
      dHitAddrR <= '0;
      bValid <= 1'b0;
      rValid <= 1'b0;
    end
    else
    begin
      if (wrFire)
      begin
        case (axiReq.awaddr)
          watchPkg::regCtrl:   ctrl <= axiReq.wdata[1:0] & {2{axiReq.wstrb[0]}} |
                                       ctrl & ~{2{axiReq.wstrb[0]}};
          watchPkg::regIWatch: iWatch <= mergeStrb(iWatch, axiReq.wdata, axiReq.wstrb);
          watchPkg::regIMask:  iMask <= mergeStrb(iMask, axiReq.wdata, axiReq.wstrb);
          watchPkg::regDWatch: dWatch <= mergeStrb(dWatch, axiReq.wdata, axiReq.wstrb);
          watchPkg::regDMask:  dMask <= mergeStrb(dMask, axiReq.wdata, axiReq.wstrb);
          default:             ;
        endcase
      end
      // a new hit wins over a clear in the same cycle
      status <= (status & ~statusClr) | {dHit, iHit};
      if (iHit)
        iHitAddrR <= iHitAddr;
      if (dHit)
        dHitAddrR <= dHitAddr;
      bValid <= wrFire | (bValid & ~axiReq.bready);
      rValid <= rdFire | (rValid & ~axiReq.rready);
    end
  end

  always_ff @(posedge CLK)
  begin
    if (rdFire)
      rData <= rdMux;
  end

  assign iEnable = ctrl[0];
  assign dEnable = ctrl[1];
  assign irq = |status;

  always_comb
  begin
    axiRsp.awready = wrFire;
    axiRsp.wready = wrFire;
    axiRsp.bvalid = bValid;
    axiRsp.bresp = watchPkg::respOkay;
    axiRsp.arready = rdFire;
    axiRsp.rvalid = rValid;
    axiRsp.rdata = rData;
    axiRsp.rresp = watchPkg::respOkay;
  end

endmodule

// ==== src/watchTop.sv ====
`timescale 1ns/100ps

module watchTop
(
  input  logic CLK,
  input  logic arstN,
  input  watchPkg::iReqT iReq,
  input  logic iMiss,
  input  logic iFill,
  input  watchPkg::dReqT dReq,
  input  logic xcpn,
  input  logic dMiss,
  input  logic dFill,
  input  logic [watchPkg::dataW-1:0] storeData,
  input  logic [watchPkg::dataW-1:0] loadData,
  input  logic [watchPkg::dataW-1:0] fillData,
  input  watchPkg::axiLiteReqT axiReq,
  output logic iSample,
  output watchPkg::iSampleT iSampleData,
  output logic dSample,
  output watchPkg::dSampleT dSampleData,
  output watchPkg::axiLiteRspT axiRsp,
  output logic irq
);

  logic iEnable;
  logic dEnable;
  logic [watchPkg::addrW-1:0] iWatch;
  logic [watchPkg::addrW-1:0] iMask;
  logic [watchPkg::addrW-1:0] dWatch;
  logic [watchPkg::addrW-1:0] dMask;
  logic iHit;
  logic dHit;
  logic [watchPkg::addrW-1:0] iHitAddr;
  logic [watchPkg::addrW-1:0] dHitAddr;

  accessSampler i_accessSampler
  (
    .CLK         (CLK),
    .arstN       (arstN),
    .iReq        (iReq),
    .dReq        (dReq),
    .iMiss       (iMiss),
    .iFill       (iFill),
    .dMiss       (dMiss),
    .dFill       (dFill),
    .xcpn        (xcpn),
    .storeData   (storeData),
    .loadData    (loadData),
    .fillData    (fillData),
    .iSample     (iSample),
    .iSampleData (iSampleData),
    .dSample     (dSample),
    .dSampleData (dSampleData)
  );

  watchMatcher #(.sampleT(watchPkg::iSampleT)) i_iMatcher
  (
    .CLK         (CLK),
    .arstN       (arstN),
    .enable      (iEnable),
    .watchAddr   (iWatch),
    .watchMask   (iMask),
    .sampleValid (iSample),
    .sample      (iSampleData),
    .hit         (iHit),
    .hitAddr     (iHitAddr)
  );

  watchMatcher #(.sampleT(watchPkg::dSampleT)) i_dMatcher
  (
    .CLK         (CLK),
    .arstN       (arstN),
    .enable      (dEnable),
    .watchAddr   (dWatch),
    .watchMask   (dMask),
    .sampleValid (dSample),
    .sample      (dSampleData),
    .hit         (dHit),
    .hitAddr     (dHitAddr)
  );

  watchRegs i_watchRegs
  (
    .CLK      (CLK),
    .arstN    (arstN),
    .axiReq   (axiReq),
    .axiRsp   (axiRsp),
    .iHit     (iHit),
    .dHit     (dHit),
    .iHitAddr (iHitAddr),
    .dHitAddr (dHitAddr),
    .iEnable  (iEnable),
    .dEnable  (dEnable),
    .iWatch   (iWatch),
    .iMask    (iMask),
    .dWatch   (dWatch),
    .dMask    (dMask),
    .irq      (irq)
  );

endmodule

// ==== tests/watchTb_assert.sv ====
`timescale 1ns/100ps

module watchTbAssert
(
  input logic CLK,
  input logic arstN,
  input watchPkg::iReqT iReq,
  input logic iMiss,
  input logic iFill,
  input watchPkg::dReqT dReq,
  input logic xcpn,
  input logic dMiss,
  input logic dFill,
  input logic [watchPkg::dataW-1:0] storeData,
  input logic [watchPkg::dataW-1:0] loadData,
  input logic [watchPkg::dataW-1:0] fillData,
  input logic iSample,
  input watchPkg::iSampleT iSampleData,
  input logic dSample,
  input watchPkg::dSampleT dSampleData,
  input logic irq
);

  int iValidErr = 0;
  int iAddrErr = 0;
  int dValidErr = 0;
  int dDataErr = 0;
  int resetErr = 0;

  // instruction side model
  logic iPrev;
  logic iWait;
  logic iFillD;
  logic iAccept;
  logic iExp;
  logic [watchPkg::addrW-1:0] iAddr;

  // data side model, E to M to W
  logic mLoad;
  logic mStore;
  logic [watchPkg::byteEnW-1:0] mByteEn;
  logic [watchPkg::addrW-1:0] mAddr;
  logic wLoad;
  logic wStore;
  logic [watchPkg::byteEnW-1:0] wByteEn;
  logic [watchPkg::addrW-1:0] wAddr;
  logic dWait;
  logic dFillD;
  logic stall;
  logic dExp;
  logic [watchPkg::dataW-1:0] fillCap;
  watchPkg::dSampleT expD;

  // requests during an outstanding miss are dropped
  assign iAccept = iReq.valid & ~iWait & ~(iPrev & iMiss);
  assign iExp = (iPrev & ~iMiss) | iFillD;
  assign stall = dWait | (wLoad & dMiss);
  assign dExp = wStore | (wLoad & ~dMiss & ~dWait) | dFillD;

  always_ff @(posedge CLK or negedge arstN)
  begin
    if (!arstN)
    begin
      iPrev <= 1'b0;
      iWait <= 1'b0;
      iFillD <= 1'b0;
      mLoad <= 1'b0;
      mStore <= 1'b0;
      wLoad <= 1'b0;
      wStore <= 1'b0;
      dWait <= 1'b0;
      dFillD <= 1'b0;
    end
    else
    begin
      iPrev <= iAccept;
      iWait <= (iPrev & iMiss) | (iWait & ~iFill);
      iFillD <= iFill & iWait;
      if (stall)
      begin
        mLoad <= mLoad & ~xcpn;
        mStore <= mStore & ~xcpn;
      end
      else
      begin
        mLoad <= dReq.read;
        mStore <= dReq.write;
        wLoad <= mLoad & ~xcpn;
        wStore <= mStore & ~xcpn;
      end
      dWait <= (wLoad & dMiss) | (dWait & ~dFill);
      dFillD <= dFill & dWait;
    end
  end

  always_ff @(posedge CLK)
  begin
    if (iAccept)
      iAddr <= iReq.addr;
    if (!stall)
    begin
      mByteEn <= dReq.byteEn;
      mAddr <= dReq.addr;
      wByteEn <= mByteEn;
      wAddr <= mAddr;
    end
    if (dFill)
      fillCap <= fillData;
  end

  always_comb
  begin
    expD.write = wStore;
    expD.byteEn = wByteEn;
    expD.addr = wAddr;
    if (dFillD)
      expD.data = fillCap;
    else if (wStore)
      expD.data = storeData;
    else
      expD.data = loadData;
  end

  iValidOk: assert property (@(posedge CLK) disable iff (!arstN) iSample == iExp)
    else
    begin
      iValidErr++;
      $error("instruction sample valid differs from the expected timing");
    end

  iAddrOk: assert property (@(posedge CLK) disable iff (!arstN)
                            iExp |-> iSampleData.addr == iAddr)
    else
    begin
      iAddrErr++;
      $error("instruction sample address is wrong");
    end

  dValidOk: assert property (@(posedge CLK) disable iff (!arstN) dSample == dExp)
    else
    begin
      dValidErr++;
      $error("data sample valid differs from the expected timing");
    end

  dDataOk: assert property (@(posedge CLK) disable iff (!arstN) dExp |-> dSampleData == expD)
    else
    begin
      dDataErr++;
      $error("data sample content is wrong");
    end

  resetQuiet: assert property (@(posedge CLK) !arstN |-> !iSample && !dSample && !irq)
    else
    begin
      resetErr++;
      $error("sample or irq active during reset");
    end

endmodule

bind watchTop watchTbAssert i_checker (.*);

// ==== tests/watchTb.sv ====
`timescale 1ns/100ps

module watchTb;

  localparam int clkPeriod = 40;
  localparam int numTests = 7;
  localparam int waitLimit = 20;

  logic CLK = 1'b0;
  logic arstN;
  watchPkg::iReqT iReq;
  logic iMiss;
  logic iFill;
  watchPkg::dReqT dReq;
  logic xcpn;
  logic dMiss;
  logic dFill;
  logic [watchPkg::dataW-1:0] storeData;
  logic [watchPkg::dataW-1:0] loadData;
  logic [watchPkg::dataW-1:0] fillData;
  watchPkg::axiLiteReqT axiReq;
  logic iSample;
  watchPkg::iSampleT iSampleData;
  logic dSample;
  watchPkg::dSampleT dSampleData;
  watchPkg::axiLiteRspT axiRsp;
  logic irq;

  int seed;
  int tbErrors = 0;
  int errMark = 0;
  int passCount = 0;
  int failCount = 0;
  logic [31:0] rnd;
  logic [31:0] iw;
  logic [31:0] dw;

  watchTop i_dut
  (
    .CLK         (CLK),
    .arstN       (arstN),
    .iReq        (iReq),
    .iMiss       (iMiss),
    .iFill       (iFill),
    .dReq        (dReq),
    .xcpn        (xcpn),
    .dMiss       (dMiss),
    .dFill       (dFill),
    .storeData   (storeData),
    .loadData    (loadData),
    .fillData    (fillData),
    .axiReq      (axiReq),
    .iSample     (iSample),
    .iSampleData (iSampleData),
    .dSample     (dSample),
    .dSampleData (dSampleData),
    .axiRsp      (axiRsp),
    .irq         (irq)
  );

  always #(clkPeriod / 2) CLK = ~CLK;

  function automatic int errorTotal();
    return tbErrors + i_dut.i_checker.iValidErr + i_dut.i_checker.iAddrErr +
           i_dut.i_checker.dValidErr + i_dut.i_checker.dDataErr + i_dut.i_checker.resetErr;
  endfunction

  task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("Mismatch at %0t: %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
      tbErrors++;
    end
  endtask

  task automatic finishTest(input string name);
    repeat (2) @(negedge CLK);
    if (errorTotal() == errMark)
    begin
      passCount++;
      $display("%s: ok", name);
    end
    else
    begin
      failCount++;
      $display("%s: FAILED", name);
    end
    errMark = errorTotal();
  endtask

  task automatic fetch(input logic [31:0] addr, input int missWait);
    int n;
    @(posedge CLK);
    iReq.valid <= 1'b1;
    iReq.addr <= addr;
    @(posedge CLK);
    iReq.valid <= 1'b0;
    if (missWait > 0)
    begin
      iMiss <= 1'b1;
      @(posedge CLK);
      iMiss <= 1'b0;
      repeat (missWait) @(posedge CLK);
      iFill <= 1'b1;
      @(posedge CLK);
      iFill <= 1'b0;
    end
    n = 0;
    do
    begin
      @(negedge CLK);
      n++;
    end
    while (!iSample && n < waitLimit);
    if (!iSample)
    begin
      $display("No instruction sample for fetch of 0x%08h at %0t", addr, $time);
      tbErrors++;
    end
  endtask

  task automatic dataAccess(input logic isWrite, input logic [31:0] addr,
                            input logic [3:0] byteEn, input logic [31:0] data,
                            input int missWait, input logic cancel);
    int n;
    logic [31:0] junk;
    junk = ~data;
    @(posedge CLK);
    dReq.read <= ~isWrite;
    dReq.write <= isWrite;
    dReq.byteEn <= byteEn;
    dReq.addr <= addr;
    @(posedge CLK);
    dReq.read <= 1'b0;
    dReq.write <= 1'b0;
    if (missWait > 0)
    begin
      // a store right behind the load waits in M during the miss
      dReq.write <= 1'b1;
      dReq.addr <= addr ^ 32'h8;
    end
    xcpn <= cancel;
    @(posedge CLK);
    // W stage of the access
    dReq.write <= 1'b0;
    xcpn <= 1'b0;
    storeData <= isWrite ? data : junk;
    loadData <= (isWrite || missWait > 0) ? junk : data;
    if (missWait > 0)
    begin
      dMiss <= 1'b1;
      @(posedge CLK);
      dMiss <= 1'b0;
      repeat (missWait) @(posedge CLK);
      dFill <= 1'b1;
      fillData <= data;
      @(posedge CLK);
      dFill <= 1'b0;
      fillData <= junk;
    end
    if (cancel)
    begin
      repeat (4)
      begin
        @(negedge CLK);
        if (dSample)
        begin
          $display("Cancelled access to 0x%08h produced a data sample at %0t", addr, $time);
          tbErrors++;
        end
      end
    end
    else
    begin
      n = 0;
      do
      begin
        @(negedge CLK);
        n++;
      end
      while (!dSample && n < waitLimit);
      if (!dSample)
      begin
        $display("No data sample for access to 0x%08h at %0t", addr, $time);
        tbErrors++;
      end
    end
  endtask

  task automatic axiWrite(input logic [31:0] addr, input logic [31:0] data);
    int n;
    @(posedge CLK);
    axiReq.awvalid <= 1'b1;
    axiReq.awaddr <= addr;
    axiReq.wvalid <= 1'b1;
    axiReq.wdata <= data;
    axiReq.wstrb <= 4'hF;
    n = 0;
    do
    begin
      @(negedge CLK);
      n++;
    end
    while (!axiRsp.awready && n < waitLimit);
    if (!axiRsp.awready)
    begin
      $display("Write to 0x%08h was never accepted", addr);
      tbErrors++;
    end
    @(posedge CLK);
    axiReq.awvalid <= 1'b0;
    axiReq.wvalid <= 1'b0;
    n = 0;
    do
    begin
      @(negedge CLK);
      n++;
    end
    while (!axiRsp.bvalid && n < waitLimit);
    if (!axiRsp.bvalid)
    begin
      $display("No write response for address 0x%08h", addr);
      tbErrors++;
    end
    else
      checkValue("bresp", {30'd0, axiRsp.bresp}, {30'd0, watchPkg::respOkay});
  endtask

  task automatic axiRead(input logic [31:0] addr, input logic [31:0] exp, input string name);
    int n;
    @(posedge CLK);
    axiReq.arvalid <= 1'b1;
    axiReq.araddr <= addr;
    n = 0;
    do
    begin
      @(negedge CLK);
      n++;
    end
    while (!axiRsp.arready && n < waitLimit);
    @(posedge CLK);
    axiReq.arvalid <= 1'b0;
    n = 0;
    do
    begin
      @(negedge CLK);
      n++;
    end
    while (!axiRsp.rvalid && n < waitLimit);
    if (!axiRsp.rvalid)
    begin
      $display("No read data for register %s", name);
      tbErrors++;
    end
    else
    begin
      checkValue(name, axiRsp.rdata, exp);
      checkValue("rresp", {30'd0, axiRsp.rresp}, {30'd0, watchPkg::respOkay});
    end
  endtask

  task automatic waitIrq(input logic level);
    int n;
    n = 0;
    do
    begin
      @(negedge CLK);
      n++;
    end
    while (irq !== level && n < waitLimit);
    if (irq !== level)
    begin
      $display("irq did not go to %b by %0t", level, $time);
      tbErrors++;
    end
  endtask

  initial
  begin
    #(numTests * 200 * clkPeriod);
    $display("Timeout after %0d cycles, the tests did not finish", numTests * 200);
    $display("Test failures found");
    $finish;
  end

  initial
  begin
    seed = 84711;
    arstN <= 1'b0;
    iReq <= '0;
    iMiss <= 1'b0;
    iFill <= 1'b0;
    dReq <= '0;
    xcpn <= 1'b0;
    dMiss <= 1'b0;
    dFill <= 1'b0;
    storeData <= '0;
    loadData <= '0;
    fillData <= '0;
    axiReq <= '0;
    axiReq.bready <= 1'b1;
    axiReq.rready <= 1'b1;
    repeat (4) @(posedge CLK);
    @(negedge CLK);
    checkValue("outputs in reset",
               {24'd0, iSample, dSample, irq, axiRsp.bvalid, axiRsp.rvalid,
                axiRsp.awready, axiRsp.wready, axiRsp.arready}, 32'd0);
    @(posedge CLK);
    arstN <= 1'b1;
    finishTest("reset state");

    rnd = $random(seed);
    fetch(rnd, 0);
    finishTest("fetch hit");
    rnd = $random(seed);
    fetch(rnd, 3);
    finishTest("fetch miss");

    rnd = $random(seed);
    iw = $random(seed);
    dw = $random(seed);
    dataAccess(1'b1, iw, rnd[3:0], dw, 0, 1'b0);
    rnd = $random(seed);
    iw = $random(seed);
    dw = $random(seed);
    dataAccess(1'b0, iw, rnd[3:0], dw, 0, 1'b0);
    finishTest("store and load hit");

    rnd = $random(seed);
    iw = $random(seed);
    dw = $random(seed);
    dataAccess(1'b0, iw, rnd[3:0], dw, 4, 1'b0);
    finishTest("load miss");

    iw = $random(seed);
    dw = $random(seed);
    dataAccess(1'b1, iw, 4'hF, dw, 0, 1'b1);
    iw = $random(seed);
    dataAccess(1'b0, iw, 4'h3, dw, 0, 1'b1);
    finishTest("cancelled access");

    // low nibble of the fetch and low byte of the data address are don't-care
    iw = $random(seed);
    dw = $random(seed);
    axiWrite(watchPkg::regIWatch, iw);
    axiWrite(watchPkg::regIMask, 32'hFFFF_FFF0);
    axiWrite(watchPkg::regDWatch, dw);
    axiWrite(watchPkg::regDMask, 32'hFFFF_FF00);
    axiWrite(watchPkg::regCtrl, 32'h3);
    axiRead(watchPkg::regCtrl, 32'h3, "ctrl");
    axiRead(32'h40, 32'h0, "unmapped");
    fetch(iw ^ 32'h4, 0);
    waitIrq(1'b1);
    axiRead(watchPkg::regStatus, 32'h1, "status after fetch hit");
    axiRead(watchPkg::regIHitAddr, iw ^ 32'h4, "iHitAddr");
    rnd = $random(seed);
    dataAccess(1'b1, dw ^ 32'h20, 4'hF, rnd, 0, 1'b0);
    repeat (2) @(posedge CLK);
    axiRead(watchPkg::regStatus, 32'h3, "status after data hit");
    axiRead(watchPkg::regDHitAddr, dw ^ 32'h20, "dHitAddr");
    axiWrite(watchPkg::regStatus, 32'h3);
    waitIrq(1'b0);
    axiRead(watchPkg::regStatus, 32'h0, "status after clear");
    fetch(iw ^ 32'h100, 0);
    rnd = $random(seed);
    dataAccess(1'b0, dw ^ 32'h1000, 4'hF, rnd, 0, 1'b0);
    repeat (2) @(posedge CLK);
    axiRead(watchPkg::regStatus, 32'h0, "status after non-matching access");
    checkValue("irq", {31'd0, irq}, 32'd0);
    finishTest("watchpoints");

    $display("tests passed: %0d, failed: %0d", passCount, failCount);
    if (failCount == 0 && errorTotal() == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

// ==== project.f ====
src/watchPkg.sv
src/missTracker.sv
src/accessSampler.sv
src/watchMatcher.sv
src/watchRegs.sv
src/watchTop.sv
tests/watchTb_assert.sv
tests/watchTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module watchTb -f project.f -o simv
./obj_dir/simv +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q 'Test failures found' sim.log || ! grep -q 'All tests passed!' sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"
